// File: src.f
rtl/chip8_pkg.sv
rtl/chip8_alu.sv
rtl/chip8_regfile.sv
rtl/chip8_stack.sv
rtl/chip8_decode.sv
rtl/chip8_execute.sv
rtl/chip8_core.sv
dv/tb_clock.sv
dv/tb_chip8.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_chip8 -f src.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// File: dv/tb_chip8.sv
// Directed tests, reference model, compare tasks and cycle limit for the CHIP-8 core
`timescale 1ns/10ps

module tb_chip8;
	import chip8_pkg::*;

	// About ten cycles for each of the roughly 250 instructions issued
	localparam int MAX_CYCLES = 3000;

	logic        cpu_clk;
	logic        rst;
	logic        instr_valid;
	logic        instr_ready;
	instr_t      instr;
	logic        retire_valid;
	logic        retire_ready;
	retire_t     retire;

	// Reference model state
	byte_t       mv [16];
	pc_t         mi;
	pc_t         mpc;
	pc_t         mstk [$];

	// Words for the next run
	instr_t      prog [$];
	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          tests;
	int          cycle_count = 0;

	tb_clock u_clock (
		.cpu_clk(cpu_clk),
		.rst    (rst)
	);

	chip8_core #(
		.STACK_DEPTH(DEFAULT_STACK_DEPTH)
	) u_dut (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire      (retire)
	);

	always @(posedge cpu_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	// Xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// 8xyN rules, a is Vx and b is Vy
	function automatic void ref_alu(input logic [3:0] fn, input byte_t a, input byte_t b,
			output byte_t res, output logic flag);
		flag = 1'b0;
		res = b;
		case (fn)
			4'h1: res = a | b;
			4'h2: res = a & b;
			4'h3: res = a ^ b;
			4'h4: begin
				res = a + b;
				flag = (int'(a) + int'(b)) > 255;
			end
			4'h5: begin
				res = a - b;
				flag = (a >= b);
			end
			4'h6: begin
				res = a >> 1;
				flag = a[0];
			end
			4'h7: begin
				res = b - a;
				flag = (b >= a);
			end
			4'hE: begin
				res = a << 1;
				flag = a[7];
			end
			default: res = b;
		endcase
	endfunction

	// Executes one word on the model and returns the expected retire record
	function automatic retire_t model_step(input instr_t w);
		retire_t  r;
		reg_idx_t x;
		reg_idx_t y;
		byte_t    kk;
		pc_t      nnn;
		byte_t    res;
		logic     flag;
		x = w[11:8];
		y = w[7:4];
		kk = w[7:0];
		nnn = w[11:0];
		r = '0;
		r.pc = mpc;
		r.next_pc = mpc + 12'd2;
		case (w[15:12])
			4'h0: begin
				if (w == 16'h00EE)
					r.next_pc = mstk.pop_back();
				else
					r.illegal = 1'b1;
			end
			4'h1: r.next_pc = nnn;
			4'h2: begin
				mstk.push_back(mpc + 12'd2);
				r.next_pc = nnn;
			end
			4'h3: if (mv[x] == kk) r.next_pc = mpc + 12'd4;
			4'h4: if (mv[x] != kk) r.next_pc = mpc + 12'd4;
			4'h5: begin
				if (w[3:0] != 4'h0)
					r.illegal = 1'b1;
				else if (mv[x] == mv[y])
					r.next_pc = mpc + 12'd4;
			end
			4'h6: begin
				r.v_we = 1'b1;
				r.v_data = kk;
			end
			4'h7: begin
				r.v_we = 1'b1;
				r.v_data = mv[x] + kk;
			end
			4'h8: begin
				if (w[3:0] > 4'h7 && w[3:0] != 4'hE) begin
					r.illegal = 1'b1;
				end else begin
					ref_alu(w[3:0], mv[x], mv[y], res, flag);
					r.v_we = 1'b1;
					r.v_data = res;
					// MOV leaves VF alone
					r.vf_we = (w[3:0] != 4'h0);
					r.vf_data = {7'b0, flag};
				end
			end
			4'h9: begin
				if (w[3:0] != 4'h0)
					r.illegal = 1'b1;
				else if (mv[x] != mv[y])
					r.next_pc = mpc + 12'd4;
			end
			4'hA: begin
				r.i_we = 1'b1;
				r.i_data = nnn;
			end
			4'hB: r.next_pc = nnn + {4'h0, mv[0]};
			4'hF: begin
				if (kk == 8'h1E) begin
					r.i_we = 1'b1;
					r.i_data = mi + {4'h0, mv[x]};
				end else if (kk == 8'h29) begin
					r.i_we = 1'b1;
					r.i_data = 12'd5 * {8'h0, mv[x][3:0]};
				end else begin
					r.illegal = 1'b1;
				end
			end
			default: r.illegal = 1'b1;
		endcase
		// Vx first, then VF, so the flag wins when x is F
		if (r.v_we) begin
			r.v_idx = x;
			mv[x] = r.v_data;
		end
		if (r.vf_we)
			mv[15] = r.vf_data;
		if (r.i_we)
			mi = r.i_data;
		mpc = r.next_pc;
		return r;
	endfunction

	// Data fields only count where their enable is set
	task automatic check_retire(input retire_t got, input retire_t exp);
		compare_pc("pc", got.pc, exp.pc);
		compare_pc("next_pc", got.next_pc, exp.next_pc);
		compare_flag("v_we", got.v_we, exp.v_we);
		compare_flag("vf_we", got.vf_we, exp.vf_we);
		compare_flag("i_we", got.i_we, exp.i_we);
		compare_flag("illegal", got.illegal, exp.illegal);
		if (exp.v_we) begin
			compare_idx("v_idx", got.v_idx, exp.v_idx);
			compare_byte("v_data", got.v_data, exp.v_data);
		end
		if (exp.vf_we)
			compare_byte("vf_data", got.vf_data, exp.vf_data);
		if (exp.i_we)
			compare_pc("i_data", got.i_data, exp.i_data);
	endtask

	// Drives prog through the core; one word in flight, or back to back with random stalls
	task automatic exec_prog(input logic stall_mode);
		retire_t     exp_q [$];
		retire_t     held;
		logic        holding;
		logic [31:0] r;
		int          sent;
		int          got;
		int          cyc;
		int          acc_cyc;
		sent = 0;
		got = 0;
		cyc = 0;
		acc_cyc = 0;
		holding = 1'b0;
		while (got < prog.size()) begin
			@(posedge cpu_clk);
			#1;
			if (stall_mode) begin
				r = next_random();
				retire_ready = r[0];
			end else begin
				retire_ready = 1'b1;
			end
			if (sent < prog.size() && (stall_mode || got == sent)) begin
				instr_valid = 1'b1;
				instr = prog[sent];
			end else begin
				instr_valid = 1'b0;
			end
			// Mid-cycle, all handshake signals are settled
			@(negedge cpu_clk);
			cyc++;
			if (instr_valid && instr_ready) begin
				exp_q.push_back(model_step(prog[sent]));
				sent++;
				acc_cyc = cyc;
			end
			if (holding && !retire_valid)
				report_error("retire_valid dropped while the record was stalled");
			if (retire_valid) begin
				if (holding && retire !== held)
					report_error("retire record changed while stalled");
				if (retire_ready) begin
					if (exp_q.size() == 0) begin
						report_error("a retire arrived with no instruction outstanding");
					end else begin
						if (!stall_mode && cyc != acc_cyc + 2)
							report_error($sformatf("retire latency was %0d cycles, expected 1",
								cyc - acc_cyc - 1));
						check_retire(retire, exp_q.pop_front());
					end
					got++;
					holding = 1'b0;
				end else begin
					holding = 1'b1;
					held = retire;
				end
			end else begin
				holding = 1'b0;
			end
		end
		prog.delete();
	endtask

	task automatic end_test(input string name, input int start);
		tests++;
		if (errors == start)
			$display("%-14s passed", name);
		else
			$display("%-14s %0d errors", name, errors - start);
	endtask

	task automatic test_reset_illegal();
		int start;
		start = errors;
		@(negedge cpu_clk);
		compare_flag("retire_valid", retire_valid, 1'b0);
		compare_flag("instr_ready", instr_ready, 1'b1);
		// Draw, clear, key skip, key wait, timer, bad 8xy function, random
		prog = '{16'hD125, 16'h00E0, 16'hE19E, 16'hF00A, 16'hF115, 16'h8008, 16'hC0FF};
		exec_prog(1'b0);
		end_test("reset_illegal", start);
	endtask

	task automatic test_alu();
		int          start;
		logic [31:0] r;
		reg_idx_t    x;
		reg_idx_t    y;
		logic [3:0]  fn;
		start = errors;
		for (int f = 0; f < 9; f++) begin
			fn = (f == 8) ? 4'hE : 4'(f);
			// Third round targets VF as Vx
			for (int k = 0; k < 3; k++) begin
				r = next_random();
				x = (k == 2) ? FLAG_REG : r[3:0];
				y = r[7:4];
				if (y == x)
					y = x ^ 4'h1;
				prog.push_back({4'h6, x, r[15:8]});
				prog.push_back({4'h6, y, r[23:16]});
				prog.push_back({4'h8, x, y, fn});
				prog.push_back({4'h7, x, r[31:24]});
			end
		end
		exec_prog(1'b0);
		end_test("alu", start);
	endtask

	task automatic test_skips();
		int start;
		start = errors;
		// V1 = V2 = 33, V3 = 44; each form taken then not taken
		prog = '{16'h6133, 16'h6233, 16'h6344,
			16'h3133, 16'h3134, 16'h4134, 16'h4133,
			16'h5120, 16'h5130, 16'h9130, 16'h9120};
		exec_prog(1'b0);
		end_test("skips", start);
	endtask

	task automatic test_jumps();
		int start;
		start = errors;
		// Three nested calls, three returns, then JP V0 wrapping past FFF
		prog = '{16'h6005, 16'h1300, 16'hB400, 16'h2500, 16'h2600, 16'h2700,
			16'h00EE, 16'h00EE, 16'h00EE, 16'hBFFF, 16'h1200};
		exec_prog(1'b0);
		end_test("jumps", start);
	endtask

	task automatic test_index();
		int          start;
		logic [31:0] r;
		start = errors;
		// AFF0 plus 20 wraps I to 010
		prog = '{16'hA123, 16'h6120, 16'hF11E, 16'hAFF0, 16'hF11E,
			16'h612A, 16'hF129, 16'h62FF, 16'hF21E};
		for (int k = 0; k < 3; k++) begin
			r = next_random();
			prog.push_back({4'h6, r[3:0], r[15:8]});
			prog.push_back({4'hF, r[3:0], 8'h29});
			prog.push_back({4'hF, r[3:0], 8'h1E});
		end
		exec_prog(1'b0);
		end_test("index", start);
	endtask

	task automatic test_stream();
		int          start;
		logic [31:0] r;
		start = errors;
		for (int n = 0; n < 100; n++) begin
			r = next_random();
			prog.push_back({r[0] ? 4'h7 : 4'h6, r[11:8], r[23:16]});
		end
		exec_prog(1'b1);
		end_test("stream", start);
	endtask

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		retire_ready = 1'b0;
		rng_state = 32'd48;
		errors = 0;
		checks = 0;
		tests = 0;
		mi = '0;
		// Programs start at 0x200
		mpc = 12'h200;
		for (int i = 0; i < 16; i++)
			mv[i] = '0;
		@(negedge rst);
		test_reset_illegal();
		test_alu();
		test_skips();
		test_jumps();
		test_index();
		test_stream();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: dv/tb_clock.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic cpu_clk,
	output logic rst
);

	initial begin
		cpu_clk = 1'b0;
		forever #(PERIOD_NS / 2) cpu_clk = ~cpu_clk;
	end

	// Release just after an edge, like every other stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: rtl/chip8_core.sv
// CHIP-8 execution core top level: decode and execute stages
`timescale 1ns/10ps

module chip8_core #(
	parameter int STACK_DEPTH = chip8_pkg::DEFAULT_STACK_DEPTH
) (
	input  logic               cpu_clk,
	input  logic               rst,
	input  logic               instr_valid,
	output logic               instr_ready,
	input  chip8_pkg::instr_t  instr,
	output logic               retire_valid,
	input  logic               retire_ready,
	output chip8_pkg::retire_t retire
);
	import chip8_pkg::*;

	// Decode to execute handshake
	logic     dec_valid;
	logic     dec_ready;
	decoded_t dec;
	// Retired next_pc back to the pc predictor
	logic     pc_redirect_valid;
	pc_t      pc_redirect;

	chip8_decode u_decode (
		.cpu_clk          (cpu_clk),
		.rst              (rst),
		.instr_valid      (instr_valid),
		.instr_ready      (instr_ready),
		.instr            (instr),
		.dec_valid        (dec_valid),
		.dec_ready        (dec_ready),
		.dec              (dec),
		.pc_redirect_valid(pc_redirect_valid),
		.pc_redirect      (pc_redirect)
	);

	chip8_execute #(
		.STACK_DEPTH(STACK_DEPTH)
	) u_execute (
		.cpu_clk          (cpu_clk),
		.rst              (rst),
		.dec_valid        (dec_valid),
		.dec_ready        (dec_ready),
		.dec              (dec),
		.retire_valid     (retire_valid),
		.retire_ready     (retire_ready),
		.retire           (retire),
		.pc_redirect_valid(pc_redirect_valid),
		.pc_redirect      (pc_redirect)
	);

endmodule

// File: rtl/chip8_execute.sv
// Execute stage: PC and I registers, control, next_pc, retire register
`timescale 1ns/10ps

module chip8_execute #(
	parameter int STACK_DEPTH = chip8_pkg::DEFAULT_STACK_DEPTH
) (
	input  logic                cpu_clk,
	input  logic                rst,
	input  logic                dec_valid,
	output logic                dec_ready,
	input  chip8_pkg::decoded_t dec,
	output logic                retire_valid,
	input  logic                retire_ready,
	output chip8_pkg::retire_t  retire,
	output logic                pc_redirect_valid,
	output chip8_pkg::pc_t      pc_redirect
);
	import chip8_pkg::*;

	pc_t      pc_q;
	pc_t      i_q;
	retire_t  nxt;
	logic     fire;
	reg_idx_t rd_a_idx;
	byte_t    rd_a;
	byte_t    rd_b;
	alu_op_t  alu_op;
	byte_t    alu_b;
	byte_t    alu_result;
	logic     alu_flag;
	pc_t      stk_top;
	logic     call_req;
	logic     ret_req;
	pc_t      pc_seq;
	pc_t      pc_skip;

	// Advance unless the retire slot is full and stalled
	assign dec_ready = !retire_valid || retire_ready;
	assign fire = dec_valid && dec_ready;

	// Bnnn reads V0 through port A
	assign rd_a_idx = (dec.op == OP_JP_V0) ? '0 : dec.x;
	// 7xkk shares the adder, its flag is dropped below
	assign alu_op = (dec.op == OP_ADD_IMM) ? ALU_ADD : dec.alu_op;
	assign alu_b = (dec.op == OP_ADD_IMM) ? dec.kk : rd_b;

	assign pc_seq = dec.pc + PC_STEP;
	assign pc_skip = pc_seq + PC_STEP;

	chip8_regfile u_regfile (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.rd_a_idx(rd_a_idx),
		.rd_b_idx(dec.y),
		.rd_a    (rd_a),
		.rd_b    (rd_b),
		.v_we    (fire && nxt.v_we),
		.v_idx   (nxt.v_idx),
		.v_data  (nxt.v_data),
		.vf_we   (fire && nxt.vf_we),
		.vf_data (nxt.vf_data)
	);

	chip8_alu u_alu (
		.op    (alu_op),
		.a     (rd_a),
		.b     (alu_b),
		.result(alu_result),
		.flag  (alu_flag)
	);

	chip8_stack #(
		.STACK_DEPTH(STACK_DEPTH)
	) u_stack (
		.cpu_clk  (cpu_clk),
		.rst      (rst),
		.push     (fire && call_req),
		.pop      (fire && ret_req),
		.push_addr(pc_seq),
		.top      (stk_top)
	);

	always_comb begin
		nxt = '0;
		nxt.pc = dec.pc;
		nxt.next_pc = pc_seq;
		nxt.v_idx = dec.x;
		nxt.v_data = alu_result;
		nxt.vf_data = {7'b0, alu_flag};
		call_req = 1'b0;
		ret_req = 1'b0;
		case (dec.op)
			OP_RET: begin
				nxt.next_pc = stk_top;
				ret_req = 1'b1;
			end
			OP_JP: nxt.next_pc = dec.nnn;
			OP_JP_V0: nxt.next_pc = dec.nnn + pc_t'(rd_a);
			OP_CALL: begin
				nxt.next_pc = dec.nnn;
				call_req = 1'b1;
			end
			// Taken skips hop over one word
			OP_SE_IMM:  if (rd_a == dec.kk) nxt.next_pc = pc_skip;
			OP_SNE_IMM: if (rd_a != dec.kk) nxt.next_pc = pc_skip;
			OP_SE_REG:  if (rd_a == rd_b) nxt.next_pc = pc_skip;
			OP_SNE_REG: if (rd_a != rd_b) nxt.next_pc = pc_skip;
			OP_LD_IMM: begin
				nxt.v_we = 1'b1;
				nxt.v_data = dec.kk;
			end
			// No carry into VF
			OP_ADD_IMM: nxt.v_we = 1'b1;
			OP_ALU_REG: begin
				nxt.v_we = 1'b1;
				// Every function but MOV updates VF, logic ops clear it
				nxt.vf_we = (dec.alu_op != ALU_MOV);
			end
			OP_LD_I: begin
				nxt.i_we = 1'b1;
				nxt.i_data = dec.nnn;
			end
			// I wraps at 12 bits
			OP_ADD_I: begin
				nxt.i_we = 1'b1;
				nxt.i_data = i_q + pc_t'(rd_a);
			end
			OP_LD_FONT: begin
				nxt.i_we = 1'b1;
				nxt.i_data = FONT_STRIDE * pc_t'(rd_a[3:0]);
			end
			default: nxt.illegal = 1'b1;
		endcase
	end

	// Tell decode where the next word lives
	assign pc_redirect_valid = fire;
	assign pc_redirect = nxt.next_pc;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			pc_q <= PC_RESET;
			i_q <= '0;
		end else begin
			if (fire) begin
				retire_valid <= 1'b1;
				pc_q <= nxt.next_pc;
				if (nxt.i_we)
					i_q <= nxt.i_data;
			end else if (retire_ready) begin
				retire_valid <= 1'b0;
			end
		end
	end

	// Retire record holds while stalled
	always_ff @(posedge cpu_clk) begin
		if (fire)
			retire <= nxt;
	end

	// Decode's pc stamp must track the architectural PC
	a_pc_match: assert property (@(posedge cpu_clk) disable iff (rst)
		dec_valid |-> dec.pc == pc_q);

endmodule

// File: rtl/chip8_decode.sv
// Decode stage with instruction classification, field extraction, pc stamp and pipeline register
`timescale 1ns/10ps

module chip8_decode (
	input  logic               cpu_clk,
	input  logic               rst,
	input  logic               instr_valid,
	output logic               instr_ready,
	input  chip8_pkg::instr_t  instr,
	output logic               dec_valid,
	input  logic               dec_ready,
	output chip8_pkg::decoded_t dec,
	input  logic               pc_redirect_valid,
	input  chip8_pkg::pc_t     pc_redirect
);
	import chip8_pkg::*;

	decoded_t dec_d;
	pc_t      pred_pc;
	logic     instr_fire;

	// Register is free when empty or draining this cycle
	assign instr_ready = !dec_valid || dec_ready;
	assign instr_fire = instr_valid && instr_ready;

	always_comb begin
		dec_d.x = instr[11:8];
		dec_d.y = instr[7:4];
		dec_d.kk = instr[7:0];
		dec_d.nnn = instr[11:0];
		dec_d.pc = pred_pc;
		dec_d.op = OP_ILLEGAL;
		dec_d.alu_op = ALU_MOV;
		// Top nibble picks the class, low bits refine it
		case (instr[15:12])
			4'h0: if (instr == 16'h00EE) dec_d.op = OP_RET;
			4'h1: dec_d.op = OP_JP;
			4'h2: dec_d.op = OP_CALL;
			4'h3: dec_d.op = OP_SE_IMM;
			4'h4: dec_d.op = OP_SNE_IMM;
			4'h5: if (instr[3:0] == 4'h0) dec_d.op = OP_SE_REG;
			4'h6: dec_d.op = OP_LD_IMM;
			4'h7: dec_d.op = OP_ADD_IMM;
			4'h8: begin
				dec_d.op = OP_ALU_REG;
				case (instr[3:0])
					4'h0: dec_d.alu_op = ALU_MOV;
					4'h1: dec_d.alu_op = ALU_OR;
					4'h2: dec_d.alu_op = ALU_AND;
					4'h3: dec_d.alu_op = ALU_XOR;
					4'h4: dec_d.alu_op = ALU_ADD;
					4'h5: dec_d.alu_op = ALU_SUB;
					4'h6: dec_d.alu_op = ALU_SHR;
					4'h7: dec_d.alu_op = ALU_SUBN;
					4'hE: dec_d.alu_op = ALU_SHL;
					default: dec_d.op = OP_ILLEGAL;
				endcase
			end
			4'h9: if (instr[3:0] == 4'h0) dec_d.op = OP_SNE_REG;
			4'hA: dec_d.op = OP_LD_I;
			4'hB: dec_d.op = OP_JP_V0;
			4'hF: begin
				if (instr[7:0] == 8'h1E)
					dec_d.op = OP_ADD_I;
				else if (instr[7:0] == 8'h29)
					dec_d.op = OP_LD_FONT;
			end
			// Draw, keys, timers, random and memory ops land here
			default: dec_d.op = OP_ILLEGAL;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			pred_pc <= PC_RESET;
		end else begin
			if (instr_fire)
				dec_valid <= 1'b1;
			else if (dec_ready)
				dec_valid <= 1'b0;
			// A word accepted now is younger than the one retiring now
			if (instr_fire)
				pred_pc <= pred_pc + PC_STEP;
			// Retired next_pc overrides the guess once decode drains
			else if (pc_redirect_valid)
				pred_pc <= pc_redirect;
		end
	end

	// Payload only
	always_ff @(posedge cpu_clk) begin
		if (instr_fire)
			dec <= dec_d;
	end

	// Held instruction must not slip while execute stalls
	a_dec_hold: assert property (@(posedge cpu_clk) disable iff (rst)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

// File: rtl/chip8_stack.sv
// Return address LIFO with depth parameter and misuse assertions
`timescale 1ns/10ps

module chip8_stack #(
	parameter int STACK_DEPTH = chip8_pkg::DEFAULT_STACK_DEPTH
) (
	input  logic           cpu_clk,
	input  logic           rst,
	input  logic           push,
	input  logic           pop,
	input  chip8_pkg::pc_t push_addr,
	output chip8_pkg::pc_t top
);
	import chip8_pkg::*;

	localparam int PTR_W = $clog2(STACK_DEPTH);
	localparam logic [PTR_W:0] FULL = (PTR_W + 1)'(STACK_DEPTH);

	pc_t              mem [STACK_DEPTH];
	// Count of entries, one bit wider than an index
	logic [PTR_W:0]   sp;
	logic [PTR_W-1:0] top_idx;

	assign top_idx = PTR_W'(sp - 1'b1);
	assign top = mem[top_idx];

	always_ff @(posedge cpu_clk) begin
		if (rst)
			sp <= '0;
		else if (push)
			sp <= sp + 1'b1;
		else if (pop)
			sp <= sp - 1'b1;
	end

	always_ff @(posedge cpu_clk) begin
		if (push)
			mem[sp[PTR_W-1:0]] <= push_addr;
	end

	// Program nesting beyond the configured depth
	a_no_overflow: assert property (@(posedge cpu_clk) disable iff (rst)
		push |-> sp != FULL);
	// RET without a matching CALL
	a_no_underflow: assert property (@(posedge cpu_clk) disable iff (rst)
		pop |-> sp != '0);
	// One instruction is never both CALL and RET
	a_one_op: assert property (@(posedge cpu_clk) disable iff (rst)
		!(push && pop));

endmodule

// File: rtl/chip8_regfile.sv
// V0-VF register file: two combinational reads, Vx write port, VF write port
`timescale 1ns/10ps

module chip8_regfile (
	input  logic                cpu_clk,
	input  logic                rst,
	input  chip8_pkg::reg_idx_t rd_a_idx,
	input  chip8_pkg::reg_idx_t rd_b_idx,
	output chip8_pkg::byte_t    rd_a,
	output chip8_pkg::byte_t    rd_b,
	input  logic                v_we,
	input  chip8_pkg::reg_idx_t v_idx,
	input  chip8_pkg::byte_t    v_data,
	input  logic                vf_we,
	input  chip8_pkg::byte_t    vf_data
);
	import chip8_pkg::*;

	byte_t v [16];

	// Reads see the value before this edge's write
	assign rd_a = v[rd_a_idx];
	assign rd_b = v[rd_b_idx];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				v[i] <= '0;
		end else begin
			if (v_we)
				v[v_idx] <= v_data;
			// Later assignment wins, so the flag beats a result into VF
			if (vf_we)
				v[FLAG_REG] <= vf_data;
		end
	end

endmodule

// File: rtl/chip8_alu.sv
// Combinational 8-bit ALU for the 8xyN group with VF flag output
`timescale 1ns/10ps

module chip8_alu (
	input  chip8_pkg::alu_op_t op,
	input  chip8_pkg::byte_t   a,
	input  chip8_pkg::byte_t   b,
	output chip8_pkg::byte_t   result,
	output logic               flag
);
	import chip8_pkg::*;

	// Ninth bit catches the carry
	logic [8:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = b;
		flag = 1'b0;
		case (op)
			ALU_MOV: result = b;
			ALU_OR:  result = a | b;
			ALU_AND: result = a & b;
			ALU_XOR: result = a ^ b;
			ALU_ADD: begin
				result = sum[7:0];
				flag = sum[8];
			end
			// Flag is NOT borrow
			ALU_SUB: begin
				result = a - b;
				flag = (a >= b);
			end
			ALU_SUBN: begin
				result = b - a;
				flag = (b >= a);
			end
			// Shifts act on Vx, flag takes the bit shifted out
			ALU_SHR: begin
				result = {1'b0, a[7:1]};
				flag = a[0];
			end
			ALU_SHL: begin
				result = {a[6:0], 1'b0};
				flag = a[7];
			end
			default: result = b;
		endcase
	end

endmodule

// File: rtl/chip8_pkg.sv
// Shared widths, reset PC, opcode and ALU enums, decoded and retire records
package chip8_pkg;

	// Scalar types
	typedef logic [11:0] pc_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] instr_t;

	// Program counter after reset and per instruction
	localparam pc_t PC_RESET = 12'h200;
	localparam pc_t PC_STEP = 12'd2;

	// VF holds carry, borrow and shift-out
	localparam reg_idx_t FLAG_REG = 4'hF;

	// Each hex glyph of the built-in font is five bytes tall
	localparam pc_t FONT_STRIDE = 12'd5;

	localparam int DEFAULT_STACK_DEPTH = 16;

	// Instruction classes after decode
	typedef enum logic [3:0] {
		OP_RET,
		OP_JP,
		OP_JP_V0,
		OP_CALL,
		OP_SE_IMM,
		OP_SNE_IMM,
		OP_SE_REG,
		OP_SNE_REG,
		OP_LD_IMM,
		OP_ADD_IMM,
		OP_ALU_REG,
		OP_LD_I,
		OP_ADD_I,
		OP_LD_FONT,
		OP_ILLEGAL
	} op_t;

	// 8xyN functions
	typedef enum logic [3:0] {
		ALU_MOV,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SUBN,
		ALU_SHR,
		ALU_SHL
	} alu_op_t;

	// One instruction between decode and execute
	typedef struct packed {
		op_t      op;
		reg_idx_t x;
		reg_idx_t y;
		byte_t    kk;
		pc_t      nnn;
		alu_op_t  alu_op;
		pc_t      pc;
	} decoded_t;

	// One retired instruction with its architectural effects
	typedef struct packed {
		pc_t      pc;
		pc_t      next_pc;
		logic     v_we;
		reg_idx_t v_idx;
		byte_t    v_data;
		logic     vf_we;
		byte_t    vf_data;
		logic     i_we;
		pc_t      i_data;
		logic     illegal;
	} retire_t;

endpackage
